//--- fetch_ctrl.sv
// fetch address, valid flag and global history with next-block selection
// also drives return stack strobes and the table update enables
`timescale 1ns/1ps
`include "frontend_consts.svh"

module fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   irq,
  input  frontend_pkg::addr_t    irq_ip,
  input  logic                   resolve_valid,
  input  frontend_pkg::addr_t    resolve_ip,
  input  frontend_pkg::br_kind_t resolve_kind,
  input  logic                   resolve_taken,
  input  frontend_pkg::addr_t    resolve_target,
  input  logic                   resolve_mispredict,
  input  frontend_pkg::hist_t    resolve_hist,
  input  logic                   btb_hit,
  input  frontend_pkg::br_kind_t btb_kind,
  input  frontend_pkg::addr_t    btb_target,
  input  logic                   pred_taken,
  input  frontend_pkg::addr_t    rs_top,
  output frontend_pkg::addr_t    fetch_ip,
  output logic                   fetch_valid,
  output frontend_pkg::hist_t    hist,
  output logic                   rs_push,
  output logic                   rs_pop,
  output frontend_pkg::addr_t    rs_push_addr,
  output logic                   install_en,
  output logic                   train_en
);

  localparam int OFF_W = $clog2(`FE_BLOCK_BYTES);
  localparam frontend_pkg::addr_t BLK_STEP = frontend_pkg::addr_t'(`FE_BLOCK_BYTES);

  frontend_pkg::addr_t seq_ip;
  frontend_pkg::addr_t next_ip;
  frontend_pkg::hist_t next_hist;
  logic                take_push;
  logic                take_pop;

  assign seq_ip = fetch_ip + BLK_STEP;

  // irq first, then mispredict, stall and the target buffer
  always_comb begin
    next_ip   = seq_ip;
    next_hist = hist;
    take_push = 1'b0;
    take_pop  = 1'b0;
    if (irq) begin
      next_ip   = irq_ip;
      take_push = 1'b1;  // handler returns to the next block
    end else if (resolve_valid && resolve_mispredict) begin
      next_ip   = resolve_taken ? resolve_target : resolve_ip + BLK_STEP;
      next_hist = {resolve_hist[`FE_HIST_W-2:0], resolve_taken};
    end else if (stall) begin
      next_ip = fetch_ip;
    end else if (btb_hit) begin
      unique case (btb_kind)
        frontend_pkg::BR_JUMP: next_ip = btb_target;
        frontend_pkg::BR_CALL: begin
          next_ip   = btb_target;
          take_push = 1'b1;
        end
        frontend_pkg::BR_RET: begin
          next_ip  = rs_top;
          take_pop = 1'b1;
        end
        frontend_pkg::BR_COND: begin
          if (pred_taken) next_ip = btb_target;
          next_hist = {hist[`FE_HIST_W-2:0], pred_taken};  // speculative
        end
      endcase
    end
  end

  assign rs_push      = fetch_valid && take_push;
  assign rs_pop       = fetch_valid && take_pop;
  assign rs_push_addr = seq_ip;
  assign install_en   = resolve_valid && resolve_taken;
  assign train_en     = resolve_valid && resolve_mispredict &&
                        resolve_kind == frontend_pkg::BR_COND;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip    <= `FE_RESET_IP;
      fetch_valid <= 1'b0;
      hist        <= '0;
    end else if (!fetch_valid) begin
      fetch_valid <= 1'b1;  // first block is the reset address
    end else begin
      fetch_ip <= next_ip;
      hist     <= next_hist;
    end
  end

  // irq vectors and buffer targets must all land on block boundaries
  a_fetch_aligned : assert property (@(posedge clk) disable iff (rst)
    fetch_valid |-> fetch_ip[OFF_W-1:0] == '0);

endmodule

//--- frontend_consts.svh
// widths, depths and the reset address of the fetch frontend
// include before any frontend package or module that sizes itself from these
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

`define FE_ADDR_W 32
`define FE_HIST_W 14

// one fetch block per cycle
`define FE_BLOCK_BYTES 32

`define FE_BTB_ENTRIES 64
`define FE_RS_DEPTH 8

`define FE_RESET_IP 32'h0000_1000

// history lengths seen by the three predictor tables
`define FE_HIST_A 2
`define FE_HIST_B 8
`define FE_HIST_C 14

`endif

//--- frontend_pkg.sv
// shared types of the fetch frontend
// modules refer to them by scoped name
`include "frontend_consts.svh"

package frontend_pkg;

  typedef logic [`FE_ADDR_W-1:0] addr_t;

  // newest outcome sits in bit 0
  typedef logic [`FE_HIST_W-1:0] hist_t;

  // block index, address bits just above the block offset
  typedef logic [$clog2(`FE_BTB_ENTRIES)-1:0] btb_idx_t;

  typedef logic [$clog2(`FE_RS_DEPTH)-1:0] rs_ptr_t;

  typedef enum logic [1:0] {
    BR_COND = 2'd0,
    BR_JUMP = 2'd1,
    BR_CALL = 2'd2,
    BR_RET  = 2'd3
  } br_kind_t;

endpackage

//--- frontend_testdata.txt
# stall irq irq_ip rv res_ip kind taken res_tgt misp res_hist | chk_ip exp_valid exp_ip, all hex
# kind 0 cond 1 jump 2 call 3 ret; expected outputs follow the edge that samples the line
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00001020
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00001040
1 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00001040
1 1 00004000 0 00000000 0 0 00000000 0 0000 1 1 00004000
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00004020
0 0 00000000 1 00002000 1 1 00003000 1 0000 1 1 00003000
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00003020
0 0 00000000 1 00001fe0 1 0 00000000 1 0000 1 1 00002000
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00003000
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00003020
0 0 00000000 1 00005040 2 1 00006080 0 0000 1 1 00003040
0 0 00000000 1 000060a0 2 1 000070c0 0 0000 1 1 00003060
0 0 00000000 1 000070e0 3 1 00000000 0 0000 1 1 00003080
0 0 00000000 1 000060c0 3 1 00000000 0 0000 1 1 000030a0
0 0 00000000 1 00005020 1 0 00000000 1 0000 1 1 00005040
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00006080
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 000060a0
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 000070c0
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 000070e0
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 000060c0
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00005060
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00005080
0 0 00000000 1 00005100 0 1 00005800 0 0000 1 1 000050a0
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 000050c0
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 000050e0
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00005100
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00005120
0 0 00000000 1 00005100 0 1 00005800 1 0000 1 1 00005800
0 0 00000000 1 000050e0 1 0 00000000 1 0000 1 1 00005100
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00005800
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00005820
0 1 00008000 1 00007200 1 1 00007400 1 0000 1 1 00008000
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00008020
0 0 00000000 1 000071e0 1 0 00000000 1 0000 1 1 00007200
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00007400
0 0 00000000 0 00000000 0 0 00000000 0 0000 1 1 00007420

//--- frontend_top.sv
// instruction fetch frontend top level
// wires the fetch control to the target buffer, predictor and return stack
`timescale 1ns/1ps

module frontend_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   irq,
  input  frontend_pkg::addr_t    irq_ip,
  input  logic                   resolve_valid,
  input  frontend_pkg::addr_t    resolve_ip,
  input  frontend_pkg::br_kind_t resolve_kind,
  input  logic                   resolve_taken,
  input  frontend_pkg::addr_t    resolve_target,
  input  logic                   resolve_mispredict,
  input  frontend_pkg::hist_t    resolve_hist,
  output frontend_pkg::addr_t    fetch_ip,
  output logic                   fetch_valid
);

  frontend_pkg::hist_t    hist;
  logic                   btb_hit;
  frontend_pkg::br_kind_t btb_kind;
  frontend_pkg::addr_t    btb_target;
  logic                   pred_taken;
  frontend_pkg::addr_t    rs_top;
  logic                   rs_push;
  logic                   rs_pop;
  frontend_pkg::addr_t    rs_push_addr;
  logic                   install_en;
  logic                   train_en;

  fetch_ctrl i_ctrl (
    .clk, .rst, .stall, .irq, .irq_ip,
    .resolve_valid, .resolve_ip, .resolve_kind, .resolve_taken,
    .resolve_target, .resolve_mispredict, .resolve_hist,
    .btb_hit, .btb_kind, .btb_target, .pred_taken, .rs_top,
    .fetch_ip, .fetch_valid, .hist,
    .rs_push, .rs_pop, .rs_push_addr, .install_en, .train_en
  );

  hist_predictor i_pred (
    .clk, .rst, .fetch_ip, .hist, .train_en, .resolve_ip, .resolve_hist, .pred_taken
  );

  target_buffer i_btb (
    .clk, .rst, .fetch_ip, .install_en, .resolve_ip, .resolve_kind, .resolve_target,
    .btb_hit, .btb_kind, .btb_target
  );

  return_stack i_rs (
    .clk, .rst, .rs_push, .rs_pop, .rs_push_addr, .rs_top
  );

endmodule

//--- hist_predictor.sv
// conditional predictor, three one-bit tables xored together
// trained by toggling on a mispredicted conditional resolve
`timescale 1ns/1ps
`include "frontend_consts.svh"

module hist_predictor (
  input  logic                clk,
  input  logic                rst,
  input  frontend_pkg::addr_t fetch_ip,
  input  frontend_pkg::hist_t hist,
  input  logic                train_en,
  input  frontend_pkg::addr_t resolve_ip,
  input  frontend_pkg::hist_t resolve_hist,
  output logic                pred_taken
);

  localparam int OFF_W = $clog2(`FE_BLOCK_BYTES);
  localparam int IDX_W = $bits(frontend_pkg::btb_idx_t);

  logic [`FE_BTB_ENTRIES-1:0] tab_a;
  logic [`FE_BTB_ENTRIES-1:0] tab_b;
  logic [`FE_BTB_ENTRIES-1:0] tab_c;
  logic [3:0]                 miss_cnt;  // thins out training of the longer tables

  frontend_pkg::btb_idx_t rd_a;
  frontend_pkg::btb_idx_t rd_b;
  frontend_pkg::btb_idx_t rd_c;
  frontend_pkg::btb_idx_t wr_a;
  frontend_pkg::btb_idx_t wr_b;
  frontend_pkg::btb_idx_t wr_c;

  // block index xor the newest len history bits folded down to index width
  function automatic frontend_pkg::btb_idx_t tbl_idx(input frontend_pkg::addr_t ip,
                                                     input frontend_pkg::hist_t h,
                                                     input int len);
    frontend_pkg::btb_idx_t fold;
    fold = '0;
    for (int i = 0; i < `FE_HIST_W; i++) begin
      if (i < len) fold[i % IDX_W] = fold[i % IDX_W] ^ h[i];
    end
    return ip[OFF_W +: IDX_W] ^ fold;
  endfunction

  assign rd_a = tbl_idx(fetch_ip, hist, `FE_HIST_A);
  assign rd_b = tbl_idx(fetch_ip, hist, `FE_HIST_B);
  assign rd_c = tbl_idx(fetch_ip, hist, `FE_HIST_C);

  assign wr_a = tbl_idx(resolve_ip, resolve_hist, `FE_HIST_A);
  assign wr_b = tbl_idx(resolve_ip, resolve_hist, `FE_HIST_B);
  assign wr_c = tbl_idx(resolve_ip, resolve_hist, `FE_HIST_C);

  assign pred_taken = tab_a[rd_a] ^ tab_b[rd_b] ^ tab_c[rd_c];

  always_ff @(posedge clk) begin
    if (rst) begin
      tab_a    <= '0;
      tab_b    <= '0;
      tab_c    <= '0;
      miss_cnt <= '0;
    end else if (train_en) begin
      tab_a[wr_a] <= ~tab_a[wr_a];
      if (miss_cnt[1:0] == 2'b11) tab_b[wr_b] <= ~tab_b[wr_b];  // every 4th
      if (&miss_cnt) tab_c[wr_c] <= ~tab_c[wr_c];  // every 16th
      miss_cnt <= miss_cnt + 1'b1;
    end
  end

endmodule

//--- return_stack.sv
// circular return-address stack
// overflow drops the oldest entry, top changes one cycle after push or pop
`timescale 1ns/1ps
`include "frontend_consts.svh"

module return_stack (
  input  logic                clk,
  input  logic                rst,
  input  logic                rs_push,
  input  logic                rs_pop,
  input  frontend_pkg::addr_t rs_push_addr,
  output frontend_pkg::addr_t rs_top
);

  frontend_pkg::addr_t   stack_mem [`FE_RS_DEPTH];
  frontend_pkg::rs_ptr_t ptr;     // points at the current top
  frontend_pkg::rs_ptr_t ptr_up;

  assign ptr_up = ptr + 1'b1;  // wraps over the oldest entry
  assign rs_top = stack_mem[ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (rs_push) begin
      ptr <= ptr_up;
    end else if (rs_pop) begin
      ptr <= ptr - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rs_push) begin
      stack_mem[ptr_up] <= rs_push_addr;
    end
  end

endmodule

//--- sim.f
+incdir+.
frontend_pkg.sv
fetch_ctrl.sv
hist_predictor.sv
target_buffer.sv
return_stack.sv
frontend_top.sv
tb_frontend.sv

//--- target_buffer.sv
// direct-mapped target buffer, one entry per fetch block index
// looked up by the fetch address, filled from taken resolves
`timescale 1ns/1ps
`include "frontend_consts.svh"

module target_buffer (
  input  logic                   clk,
  input  logic                   rst,
  input  frontend_pkg::addr_t    fetch_ip,
  input  logic                   install_en,
  input  frontend_pkg::addr_t    resolve_ip,
  input  frontend_pkg::br_kind_t resolve_kind,
  input  frontend_pkg::addr_t    resolve_target,
  output logic                   btb_hit,
  output frontend_pkg::br_kind_t btb_kind,
  output frontend_pkg::addr_t    btb_target
);

  localparam int OFF_W = $clog2(`FE_BLOCK_BYTES);
  localparam int IDX_W = $bits(frontend_pkg::btb_idx_t);
  localparam int TAG_W = `FE_ADDR_W - OFF_W - IDX_W;  // bits 31..11

  logic [`FE_BTB_ENTRIES-1:0] valid;
  logic [TAG_W-1:0]           tag_mem  [`FE_BTB_ENTRIES];
  frontend_pkg::br_kind_t     kind_mem [`FE_BTB_ENTRIES];
  frontend_pkg::addr_t        tgt_mem  [`FE_BTB_ENTRIES];

  frontend_pkg::btb_idx_t rd_idx;
  frontend_pkg::btb_idx_t wr_idx;

  assign rd_idx = fetch_ip[OFF_W +: IDX_W];
  assign wr_idx = resolve_ip[OFF_W +: IDX_W];

  assign btb_hit    = valid[rd_idx] && tag_mem[rd_idx] == fetch_ip[`FE_ADDR_W-1 -: TAG_W];
  assign btb_kind   = kind_mem[rd_idx];
  assign btb_target = tgt_mem[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (install_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // same index simply replaces the old entry
  always_ff @(posedge clk) begin
    if (install_en) begin
      tag_mem[wr_idx]  <= resolve_ip[`FE_ADDR_W-1 -: TAG_W];
      kind_mem[wr_idx] <= resolve_kind;
      tgt_mem[wr_idx]  <= resolve_target;
    end
  end

  // whatever was installed earlier must come back block-aligned
  a_target_aligned : assert property (@(posedge clk) disable iff (rst)
    btb_hit |-> btb_target[OFF_W-1:0] == '0);

endmodule

//--- tb_frontend.sv
// testbench for the fetch frontend, replays the vector file one line per cycle
// and compares fetch_valid and fetch_ip with the expected columns
`timescale 1ns/1ps
`include "frontend_consts.svh"

module tb_frontend;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_VEC      = 64;

  logic                   clk;
  logic                   rst;
  logic                   stall;
  logic                   irq;
  frontend_pkg::addr_t    irq_ip;
  logic                   resolve_valid;
  frontend_pkg::addr_t    resolve_ip;
  frontend_pkg::br_kind_t resolve_kind;
  logic                   resolve_taken;
  frontend_pkg::addr_t    resolve_target;
  logic                   resolve_mispredict;
  frontend_pkg::hist_t    resolve_hist;
  frontend_pkg::addr_t    fetch_ip;
  logic                   fetch_valid;

  // one slot per vector line
  logic                v_stall   [MAX_VEC];
  logic                v_irq     [MAX_VEC];
  frontend_pkg::addr_t v_irq_ip  [MAX_VEC];
  logic                v_rvalid  [MAX_VEC];
  frontend_pkg::addr_t v_rip     [MAX_VEC];
  logic [1:0]          v_rkind   [MAX_VEC];
  logic                v_rtaken  [MAX_VEC];
  frontend_pkg::addr_t v_rtarget [MAX_VEC];
  logic                v_rmisp   [MAX_VEC];
  frontend_pkg::hist_t v_rhist   [MAX_VEC];
  logic                v_chk_ip  [MAX_VEC];
  logic                v_exp_vld [MAX_VEC];
  frontend_pkg::addr_t v_exp_ip  [MAX_VEC];

  int n_vec    = 0;
  int n_checks = 0;
  int n_errors = 0;
  bit loaded   = 1'b0;

  frontend_top i_dut (
    .clk, .rst, .stall, .irq, .irq_ip,
    .resolve_valid, .resolve_ip, .resolve_kind, .resolve_taken,
    .resolve_target, .resolve_mispredict, .resolve_hist,
    .fetch_ip, .fetch_valid
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_addr(input string name, input frontend_pkg::addr_t got,
                            input frontend_pkg::addr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("frontend_testdata.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("could not open frontend_testdata.txt");
      return;
    end
    while (n_vec < MAX_VEC && $fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;  // comments and blank lines
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v_stall[n_vec], v_irq[n_vec], v_irq_ip[n_vec], v_rvalid[n_vec],
                    v_rip[n_vec], v_rkind[n_vec], v_rtaken[n_vec], v_rtarget[n_vec],
                    v_rmisp[n_vec], v_rhist[n_vec], v_chk_ip[n_vec], v_exp_vld[n_vec],
                    v_exp_ip[n_vec]);
      if (cnt == 13) begin
        n_vec++;
      end else begin
        n_errors++;
        $display("malformed vector line: %s", line);
      end
    end
    $fclose(fd);
    if (n_vec == 0) begin
      n_errors++;
      $display("no vectors found in frontend_testdata.txt");
    end
  endtask

  task automatic drive_idle();
    stall              <= 1'b0;
    irq                <= 1'b0;
    irq_ip             <= '0;
    resolve_valid      <= 1'b0;
    resolve_ip         <= '0;
    resolve_kind       <= frontend_pkg::BR_COND;
    resolve_taken      <= 1'b0;
    resolve_target     <= '0;
    resolve_mispredict <= 1'b0;
    resolve_hist       <= '0;
  endtask

  task automatic drive_vector(input int i);
    stall              <= v_stall[i];
    irq                <= v_irq[i];
    irq_ip             <= v_irq_ip[i];
    resolve_valid      <= v_rvalid[i];
    resolve_ip         <= v_rip[i];
    resolve_kind       <= frontend_pkg::br_kind_t'(v_rkind[i]);
    resolve_taken      <= v_rtaken[i];
    resolve_target     <= v_rtarget[i];
    resolve_mispredict <= v_rmisp[i];
    resolve_hist       <= v_rhist[i];
  endtask

  task automatic check_line(input int i);
    check_bit("fetch_valid", fetch_valid, v_exp_vld[i]);
    if (v_chk_ip[i]) check_addr("fetch_ip", fetch_ip, v_exp_ip[i]);
  endtask

  initial begin
    rst = 1'b1;
    drive_idle();
    load_vectors();
    loaded = 1'b1;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      if (c == RESET_CYCLES - 1) rst <= 1'b0;
      #(CLK_PERIOD - 1);
      check_bit("fetch_valid", fetch_valid, 1'b0);
    end
    // outputs seen before an edge come from the line driven one edge earlier
    for (int i = 0; i < n_vec; i++) begin
      @(posedge clk);
      drive_vector(i);
      #(CLK_PERIOD - 1);
      if (i == 0) begin
        check_bit("fetch_valid", fetch_valid, 1'b1);
        check_addr("fetch_ip", fetch_ip, `FE_RESET_IP);
      end else begin
        check_line(i - 1);
      end
    end
    @(posedge clk);
    drive_idle();
    #(CLK_PERIOD - 1);
    if (n_vec > 0) check_line(n_vec - 1);
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // two cycles per vector plus reset and a little slack
  initial begin
    wait (loaded);
    #(n_vec * 8 + (RESET_CYCLES + 2) * CLK_PERIOD);
    $display("run timed out before all vectors were checked");
    $display("=== FAIL ===");
    $finish;
  end

endmodule
